// ==== rtl/id_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV64 only; XLEN is not meant to be changed alone
// opcode groups compare against inst[6:2]
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// datapath
`define XLEN 64

// integer register file
`define REG_CNT 32
`define REG_AW 5

// opcode groups, bits 6 to 2
`define OPC_LOAD    5'b00000
`define OPC_STORE   5'b01000
`define OPC_BRANCH  5'b11000
`define OPC_JALR    5'b11001
`define OPC_JAL     5'b11011

`define OPC_OP      5'b01100
`define OPC_OPIMM   5'b00100
`define OPC_OP32    5'b01110
`define OPC_OPIMM32 5'b00110

`define OPC_LUI     5'b01101
`define OPC_AUIPC   5'b00101

// csr access, ecall, ebreak, mret
`define OPC_SYSTEM  5'b11100

`endif

// ==== rtl/id_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu_op codes follow the legacy core's encoding
// except mulhsu, which had collided with srai
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "id_consts.svh"

package id_pkg;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0]      inst;
	} fetch_pkt_t;

	// zero means not recognised
	typedef enum logic [7:0] {
		ALU_NONE   = 8'h00,
		ALU_ADDI   = 8'h01, ALU_SLTI   = 8'h02, ALU_SLTIU  = 8'h04,
		ALU_XORI   = 8'h08, ALU_ORI    = 8'h10, ALU_ANDI   = 8'h20,
		ALU_SLLI   = 8'h40, ALU_SRLI   = 8'h80, ALU_SRAI   = 8'h03,
		ALU_ADD    = 8'h06, ALU_SUB    = 8'h0c, ALU_SLL    = 8'h18,
		ALU_SLT    = 8'h30, ALU_SLTU   = 8'h60, ALU_XOR    = 8'hc0,
		ALU_SRL    = 8'h05, ALU_SRA    = 8'h0a, ALU_OR     = 8'h14,
		ALU_AND    = 8'h28,
		ALU_ADDIW  = 8'h09, ALU_SLLIW  = 8'h12, ALU_SRLIW  = 8'h24,
		ALU_SRAIW  = 8'h48, ALU_ADDW   = 8'h90, ALU_SUBW   = 8'h11,
		ALU_SLLW   = 8'h22, ALU_SRLW   = 8'h44, ALU_SRAW   = 8'h88,
		ALU_MUL    = 8'h58, ALU_MULH   = 8'hb0, ALU_MULHSU = 8'h0f,
		ALU_MULHU  = 8'h36, ALU_DIV    = 8'h98, ALU_DIVU   = 8'h23,
		ALU_REM    = 8'h43, ALU_REMU   = 8'h86, ALU_MULW   = 8'h4c,
		ALU_DIVW   = 8'h8c, ALU_DIVUW  = 8'h46, ALU_REMW   = 8'h15,
		ALU_REMUW  = 8'h83,
		ALU_LB     = 8'h1a, ALU_LH     = 8'h34, ALU_LW     = 8'h68,
		ALU_LD     = 8'hd0, ALU_LBU    = 8'h0b, ALU_LHU    = 8'h16,
		ALU_LWU    = 8'h2c, ALU_SB     = 8'h41, ALU_SH     = 8'h82,
		ALU_SW     = 8'h81, ALU_SD     = 8'h07,
		ALU_BEQ    = 8'h0e, ALU_BNE    = 8'h1c, ALU_BLT    = 8'h38,
		ALU_BGE    = 8'h70, ALU_BLTU   = 8'he0, ALU_BGEU   = 8'h0d,
		ALU_LUI    = 8'h50, ALU_AUIPC  = 8'ha0, ALU_JAL    = 8'h21,
		ALU_JALR   = 8'h42,
		ALU_ECALL  = 8'h2a, ALU_EBREAK = 8'h84, ALU_MRET   = 8'h54,
		ALU_CSRRW  = 8'ha8, ALU_CSRRS  = 8'h25, ALU_CSRRC  = 8'h4a,
		ALU_CSRRWI = 8'h94, ALU_CSRRSI = 8'hc8, ALU_CSRRCI = 8'ha4
	} alu_op_e;

	// bit 3 set for loads
	typedef enum logic [3:0] {
		MEM_NONE = 4'h0, MEM_SB  = 4'h1, MEM_SH  = 4'h2, MEM_SW  = 4'h4,
		MEM_SD   = 4'h5, MEM_LB  = 4'h9, MEM_LH  = 4'ha, MEM_LW  = 4'hb,
		MEM_LD   = 4'hc, MEM_LBU = 4'hd, MEM_LHU = 4'he, MEM_LWU = 4'hf
	} mem_op_e;

	typedef enum logic [1:0] {
		WB_NONE = 2'b00,
		WB_MEM  = 2'b01,
		WB_ALU  = 2'b10
	} wb_sel_e;

	typedef struct packed {
		alu_op_e              alu_op;
		mem_op_e              mem_op;
		wb_sel_e              wb_sel;
		logic                 rs1_en;
		logic                 rs2_en;
		logic                 imm_en;
		logic                 branch;
		logic                 jump;
		logic                 ebreak;
		logic [`REG_AW-1:0]   rs1;
		logic [`REG_AW-1:0]   rs2;
		logic [`REG_AW-1:0]   rd;
		logic [`XLEN-1:0]     imm;
	} dec_ctl_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		dec_ctl_t         ctl;
		logic [`XLEN-1:0] op_a;
		logic [`XLEN-1:0] op_b;
		logic [`XLEN-1:0] store_data;
	} id_out_t;

endpackage

`default_nettype wire

// ==== rtl/stage_reg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no back-pressure; payload holds until next valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type T = logic
) (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire logic i_valid,
	input  wire T     i_data,
	output logic      o_valid,
	output T          o_data
);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// payload only moves with a valid beat
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			o_data <= i_data;
		end
	end

	a_valid_known: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) !$isunknown(o_valid)
	) else $error("stage_reg: o_valid unknown");

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV64IM plus csr, ecall, ebreak, mret only
// anything else decodes to an all-zero control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "id_consts.svh"

module inst_decoder
	import id_pkg::*;
(
	input  wire logic [31:0] i_inst,
	output dec_ctl_t         o_ctl
);

	logic [4:0]       opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [11:0]      i_imm;
	alu_op_e          op;
	logic [`XLEN-1:0] imm;

	assign opcode = i_inst[6:2];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];
	assign i_imm  = i_inst[31:20];

	// name the instruction
	always_comb begin
		op = ALU_NONE;
		if (i_inst[1:0] == 2'b11) begin
			case (opcode)
				`OPC_LOAD: begin
					case (funct3)
						3'b000: op = ALU_LB;
						3'b001: op = ALU_LH;
						3'b010: op = ALU_LW;
						3'b011: op = ALU_LD;
						3'b100: op = ALU_LBU;
						3'b101: op = ALU_LHU;
						3'b110: op = ALU_LWU;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_STORE: begin
					case (funct3)
						3'b000: op = ALU_SB;
						3'b001: op = ALU_SH;
						3'b010: op = ALU_SW;
						3'b011: op = ALU_SD;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_BRANCH: begin
					case (funct3)
						3'b000: op = ALU_BEQ;
						3'b001: op = ALU_BNE;
						3'b100: op = ALU_BLT;
						3'b101: op = ALU_BGE;
						3'b110: op = ALU_BLTU;
						3'b111: op = ALU_BGEU;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_OPIMM: begin
					case (funct3)
						3'b000: op = ALU_ADDI;
						3'b001: op = ALU_SLLI;
						3'b010: op = ALU_SLTI;
						3'b011: op = ALU_SLTIU;
						3'b100: op = ALU_XORI;
						3'b101: op = funct7[5] ? ALU_SRAI : ALU_SRLI;
						3'b110: op = ALU_ORI;
						default: op = ALU_ANDI;
					endcase
				end
				`OPC_OPIMM32: begin
					case (funct3)
						3'b000: op = ALU_ADDIW;
						3'b001: op = ALU_SLLIW;
						3'b101: op = funct7[5] ? ALU_SRAIW : ALU_SRLIW;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_OP: begin
					case ({funct7, funct3})
						{7'h00, 3'b000}: op = ALU_ADD;
						{7'h20, 3'b000}: op = ALU_SUB;
						{7'h00, 3'b001}: op = ALU_SLL;
						{7'h00, 3'b010}: op = ALU_SLT;
						{7'h00, 3'b011}: op = ALU_SLTU;
						{7'h00, 3'b100}: op = ALU_XOR;
						{7'h00, 3'b101}: op = ALU_SRL;
						{7'h20, 3'b101}: op = ALU_SRA;
						{7'h00, 3'b110}: op = ALU_OR;
						{7'h00, 3'b111}: op = ALU_AND;
						{7'h01, 3'b000}: op = ALU_MUL;
						{7'h01, 3'b001}: op = ALU_MULH;
						{7'h01, 3'b010}: op = ALU_MULHSU;
						{7'h01, 3'b011}: op = ALU_MULHU;
						{7'h01, 3'b100}: op = ALU_DIV;
						{7'h01, 3'b101}: op = ALU_DIVU;
						{7'h01, 3'b110}: op = ALU_REM;
						{7'h01, 3'b111}: op = ALU_REMU;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_OP32: begin
					case ({funct7, funct3})
						{7'h00, 3'b000}: op = ALU_ADDW;
						{7'h20, 3'b000}: op = ALU_SUBW;
						{7'h00, 3'b001}: op = ALU_SLLW;
						{7'h00, 3'b101}: op = ALU_SRLW;
						{7'h20, 3'b101}: op = ALU_SRAW;
						{7'h01, 3'b000}: op = ALU_MULW;
						{7'h01, 3'b100}: op = ALU_DIVW;
						{7'h01, 3'b101}: op = ALU_DIVUW;
						{7'h01, 3'b110}: op = ALU_REMW;
						{7'h01, 3'b111}: op = ALU_REMUW;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_SYSTEM: begin
					case (funct3)
						3'b000: begin
							case (i_imm)
								12'h000: op = ALU_ECALL;
								12'h001: op = ALU_EBREAK;
								12'h302: op = ALU_MRET;
								default: op = ALU_NONE;
							endcase
						end
						3'b001: op = ALU_CSRRW;
						3'b010: op = ALU_CSRRS;
						3'b011: op = ALU_CSRRC;
						3'b101: op = ALU_CSRRWI;
						3'b110: op = ALU_CSRRSI;
						3'b111: op = ALU_CSRRCI;
						default: op = ALU_NONE;
					endcase
				end
				`OPC_LUI: op = ALU_LUI;
				`OPC_AUIPC: op = ALU_AUIPC;
				`OPC_JAL: op = ALU_JAL;
				`OPC_JALR: op = ALU_JALR;
				default: op = ALU_NONE;
			endcase
		end
	end

	// immediate by format, sign bit always inst[31]
	always_comb begin
		case (opcode)
			`OPC_LOAD, `OPC_OPIMM, `OPC_OPIMM32, `OPC_SYSTEM, `OPC_JALR:
				imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
			`OPC_STORE:
				imm = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
			`OPC_BRANCH:
				imm = {{(`XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
					i_inst[11:8], 1'b0};
			`OPC_LUI, `OPC_AUIPC:
				imm = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
			`OPC_JAL:
				imm = {{(`XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
					i_inst[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

	always_comb begin
		o_ctl = '0;
		if (op != ALU_NONE) begin
			o_ctl.alu_op = op;
			case (op)
				ALU_SB: o_ctl.mem_op = MEM_SB;
				ALU_SH: o_ctl.mem_op = MEM_SH;
				ALU_SW: o_ctl.mem_op = MEM_SW;
				ALU_SD: o_ctl.mem_op = MEM_SD;
				ALU_LB: o_ctl.mem_op = MEM_LB;
				ALU_LH: o_ctl.mem_op = MEM_LH;
				ALU_LW: o_ctl.mem_op = MEM_LW;
				ALU_LD: o_ctl.mem_op = MEM_LD;
				ALU_LBU: o_ctl.mem_op = MEM_LBU;
				ALU_LHU: o_ctl.mem_op = MEM_LHU;
				ALU_LWU: o_ctl.mem_op = MEM_LWU;
				default: o_ctl.mem_op = MEM_NONE;
			endcase
			if (opcode == `OPC_LOAD) begin
				o_ctl.wb_sel = WB_MEM;
			end else if (opcode inside {`OPC_OP, `OPC_OPIMM, `OPC_OP32, `OPC_OPIMM32,
					`OPC_SYSTEM, `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR}) begin
				o_ctl.wb_sel = WB_ALU;
			end
			// only register-form csr ops and ecall read rs1 in SYSTEM
			o_ctl.rs1_en = (opcode inside {`OPC_OP, `OPC_OPIMM, `OPC_OP32, `OPC_OPIMM32,
					`OPC_BRANCH, `OPC_LOAD, `OPC_STORE})
				|| (op inside {ALU_JALR, ALU_CSRRW, ALU_CSRRS, ALU_CSRRC, ALU_ECALL});
			o_ctl.rs2_en = opcode inside {`OPC_OP, `OPC_OP32, `OPC_BRANCH, `OPC_STORE};
			o_ctl.imm_en = opcode inside {`OPC_STORE, `OPC_LOAD, `OPC_BRANCH, `OPC_OPIMM,
					`OPC_OPIMM32, `OPC_SYSTEM, `OPC_LUI, `OPC_AUIPC};
			o_ctl.branch = (opcode == `OPC_BRANCH);
			o_ctl.jump   = (op == ALU_JAL) || (op == ALU_JALR);
			o_ctl.ebreak = (op == ALU_EBREAK);
			o_ctl.rs1    = i_inst[19:15];
			o_ctl.rs2    = i_inst[24:20];
			o_ctl.rd     = i_inst[11:7];
			o_ctl.imm    = imm;
		end
	end

	always_comb begin
		a_br_jmp: assert (!(o_ctl.branch && o_ctl.jump))
			else $error("inst_decoder: branch and jump both set");
	end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// contents power up unknown; x0 always reads zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "id_consts.svh"

module reg_file (
	input  wire logic               i_clk,
	input  wire logic               i_we,
	input  wire logic [`REG_AW-1:0] i_wd_addr,
	input  wire logic [`XLEN-1:0]   i_wd_data,
	input  wire logic [`REG_AW-1:0] i_rs1,
	input  wire logic [`REG_AW-1:0] i_rs2,
	output logic [`XLEN-1:0]        o_rs1_data,
	output logic [`XLEN-1:0]        o_rs2_data
);

	logic [`XLEN-1:0] mem [`REG_CNT];

	always_ff @(posedge i_clk) begin
		if (i_we && (i_wd_addr != '0)) begin
			mem[i_wd_addr] <= i_wd_data;
		end
	end

	// write in flight wins over storage
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
		if (addr == '0) begin
			return '0;
		end else if (i_we && (addr == i_wd_addr)) begin
			return i_wd_data;
		end else begin
			return mem[addr];
		end
	endfunction

	always_comb begin
		o_rs1_data = read_port(i_rs1);
	end

	always_comb begin
		o_rs2_data = read_port(i_rs2);
	end

	a_x0_zero: assert property (
		@(posedge i_clk)
		((i_rs1 == '0) -> (o_rs1_data == '0)) && ((i_rs2 == '0) -> (o_rs2_data == '0))
	) else $error("reg_file: x0 read back nonzero");

endmodule

`default_nettype wire

// ==== rtl/operand_sel.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unused operands are forced to zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "id_consts.svh"

module operand_sel
	import id_pkg::*;
(
	input  wire logic [`XLEN-1:0] i_pc,
	input  wire dec_ctl_t         i_ctl,
	input  wire logic [`XLEN-1:0] i_rs1_data,
	input  wire logic [`XLEN-1:0] i_rs2_data,
	output logic [`XLEN-1:0]      o_op_a,
	output logic [`XLEN-1:0]      o_op_b,
	output logic [`XLEN-1:0]      o_store_data
);

	logic pc_src;
	logic is_store;

	// pc-relative targets and link address
	assign pc_src   = i_ctl.alu_op inside {ALU_AUIPC, ALU_JAL, ALU_JALR};
	assign is_store = i_ctl.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD};

	always_comb begin
		if (pc_src) begin
			o_op_a = i_pc;
		end else if (i_ctl.rs1_en) begin
			o_op_a = i_rs1_data;
		end else begin
			o_op_a = '0;
		end
	end

	always_comb begin
		if (i_ctl.imm_en) begin
			o_op_b = i_ctl.imm;
		end else if (i_ctl.rs2_en) begin
			o_op_b = i_rs2_data;
		end else begin
			o_op_b = '0;
		end
	end

	assign o_store_data = is_store ? i_rs2_data : '0;

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no stall or flush; every accepted beat comes out
// o_valid follows i_fetch_valid by two register stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "id_consts.svh"

module id_stage
	import id_pkg::*;
(
	input  wire logic               i_clk,
	input  wire logic               i_rst_n,
	input  wire logic               i_fetch_valid,
	input  wire fetch_pkt_t         i_fetch,
	input  wire logic               i_wb_en,
	input  wire logic [`REG_AW-1:0] i_wb_rd,
	input  wire logic [`XLEN-1:0]   i_wb_data,
	output logic                    o_valid,
	output id_out_t                 o_id
);

	logic             fetch_vld_q;
	fetch_pkt_t       fetch_q;
	dec_ctl_t         ctl;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] store_data;
	id_out_t          id_d;

	stage_reg #(.T(fetch_pkt_t)) fetch_reg (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (i_fetch_valid),
		.i_data  (i_fetch),
		.o_valid (fetch_vld_q),
		.o_data  (fetch_q)
	);

	inst_decoder decoder (
		.i_inst (fetch_q.inst),
		.o_ctl  (ctl)
	);

	// write-back port shares the cycle with decode reads
	reg_file rf (
		.i_clk      (i_clk),
		.i_we       (i_wb_en),
		.i_wd_addr  (i_wb_rd),
		.i_wd_data  (i_wb_data),
		.i_rs1      (ctl.rs1),
		.i_rs2      (ctl.rs2),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	operand_sel opsel (
		.i_pc         (fetch_q.pc),
		.i_ctl        (ctl),
		.i_rs1_data   (rs1_data),
		.i_rs2_data   (rs2_data),
		.o_op_a       (op_a),
		.o_op_b       (op_b),
		.o_store_data (store_data)
	);

	assign id_d = '{
		pc:         fetch_q.pc,
		ctl:        ctl,
		op_a:       op_a,
		op_b:       op_b,
		store_data: store_data
	};

	stage_reg #(.T(id_out_t)) out_reg (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (fetch_vld_q),
		.i_data  (id_d),
		.o_valid (o_valid),
		.o_data  (o_id)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free-running clock, starts low, even period only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

// ==== tests/id_stage_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run from the project root; reads tests/id_trace.txt
// every register an instruction reads must be written first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "id_consts.svh"

module id_stage_tb
	import id_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 20;
	localparam int RESET_CYCLES   = 4;
	localparam int DRAIN_CYCLES   = 4;

	typedef struct packed {
		logic             is_inst;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
	} stim_t;

	typedef struct packed {
		logic [7:0]         alu_op;
		logic [3:0]         mem_op;
		logic [1:0]         wb_sel;
		logic [5:0]         flags;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   imm;
		logic [`XLEN-1:0]   op_a;
		logic [`XLEN-1:0]   op_b;
		logic [`XLEN-1:0]   store_data;
	} expect_t;

	// pc and drive cycle of an instruction in flight
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0]      cycle;
	} issue_t;

	logic               clk;
	logic               rst_n;
	logic               fetch_valid;
	fetch_pkt_t         fetch;
	logic               wb_en;
	logic [`REG_AW-1:0] wb_rd;
	logic [`XLEN-1:0]   wb_data;
	logic               out_valid;
	id_out_t            out_id;

	stim_t       stim_q[$];
	expect_t     exp_q[$];
	issue_t      issue_q[$];
	int          n_inst;
	logic [31:0] cycle = '0;

	tb_clock #(.PERIOD_NS(100)) clk_gen (
		.o_clk (clk)
	);

	id_stage id_stage_inst (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_fetch_valid (fetch_valid),
		.i_fetch       (fetch),
		.i_wb_en       (wb_en),
		.i_wb_rd       (wb_rd),
		.i_wb_data     (wb_data),
		.o_valid       (out_valid),
		.o_id          (out_id)
	);

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_field(input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] want);
		assert (got === want) else begin
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, want);
			stop_with_failure();
		end
	endtask

	task automatic read_trace();
		int               fd;
		int               n;
		string            line;
		byte              tag;
		logic [`XLEN-1:0] a, b, alu, mem, wb, flg, r1, r2, rd, imm, opa, opb, sd;
		stim_t            s;
		expect_t          e;
		fd = $fopen("tests/id_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tests/id_trace.txt");
			stop_with_failure();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			tag = (line.len() > 0) ? line.getc(0) : "#";
			case (tag)
				"W", "I": begin
					if (tag == "W") begin
						n = $sscanf(line, "W %h %h", a, b);
					end else begin
						n = $sscanf(line, "I %h %h", a, b);
						n_inst++;
					end
					if (n != 2) begin
						$display("malformed trace line: %s", line);
						stop_with_failure();
					end
					s.is_inst = (tag == "I");
					s.a = a;
					s.b = b;
					stim_q.push_back(s);
				end
				"E": begin
					n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h",
						alu, mem, wb, flg, r1, r2, rd, imm, opa, opb, sd);
					if (n != 11) begin
						$display("malformed trace line: %s", line);
						stop_with_failure();
					end
					e.alu_op = alu[7:0];
					e.mem_op = mem[3:0];
					e.wb_sel = wb[1:0];
					e.flags = flg[5:0];
					e.rs1 = r1[`REG_AW-1:0];
					e.rs2 = r2[`REG_AW-1:0];
					e.rd = rd[`REG_AW-1:0];
					e.imm = imm;
					e.op_a = opa;
					e.op_b = opb;
					e.store_data = sd;
					exp_q.push_back(e);
				end
				"#", "\n", "\r", " ": begin
				end
				default: begin
					$display("unknown record in trace line: %s", line);
					stop_with_failure();
				end
			endcase
		end
		$fclose(fd);
		if (n_inst != exp_q.size()) begin
			$display("trace has %0d instructions but %0d expected records", n_inst,
				exp_q.size());
			stop_with_failure();
		end
	endtask

	// one record per falling edge, writes and instructions never overlap
	task automatic drive_records();
		stim_t  s;
		issue_t iss;
		foreach (stim_q[i]) begin
			s = stim_q[i];
			@(negedge clk);
			fetch_valid = s.is_inst;
			wb_en = !s.is_inst;
			if (s.is_inst) begin
				fetch.pc = s.a;
				fetch.inst = s.b[31:0];
				iss.pc = s.a;
				iss.cycle = cycle;
				issue_q.push_back(iss);
			end else begin
				wb_rd = s.a[`REG_AW-1:0];
				wb_data = s.b;
			end
		end
		@(negedge clk);
		fetch_valid = 1'b0;
		wb_en = 1'b0;
	endtask

	task automatic check_outputs();
		expect_t e;
		issue_t  iss;
		int      waited;
		logic    seen;
		foreach (exp_q[i]) begin
			e = exp_q[i];
			waited = 0;
			seen = 1'b0;
			while (!seen) begin
				@(negedge clk);
				if (out_valid) begin
					seen = 1'b1;
				end else begin
					waited++;
					if (waited > TIMEOUT_CYCLES) begin
						$display("timeout: o_valid never came for expected record %0d", i);
						stop_with_failure();
					end
				end
			end
			if (issue_q.size() == 0) begin
				$display("o_valid rose with no instruction in flight");
				stop_with_failure();
			end
			iss = issue_q.pop_front();
			// driven at a falling edge, out two rising edges later
			check_field("o_valid cycle", 64'(cycle), 64'(iss.cycle + 2));
			check_field("o_id.pc", out_id.pc, iss.pc);
			check_field("o_id.ctl.alu_op", 64'(out_id.ctl.alu_op), 64'(e.alu_op));
			check_field("o_id.ctl.mem_op", 64'(out_id.ctl.mem_op), 64'(e.mem_op));
			check_field("o_id.ctl.wb_sel", 64'(out_id.ctl.wb_sel), 64'(e.wb_sel));
			check_field("o_id.ctl flags", 64'({out_id.ctl.rs1_en, out_id.ctl.rs2_en,
				out_id.ctl.imm_en, out_id.ctl.branch, out_id.ctl.jump,
				out_id.ctl.ebreak}), 64'(e.flags));
			check_field("o_id.ctl.rs1", 64'(out_id.ctl.rs1), 64'(e.rs1));
			check_field("o_id.ctl.rs2", 64'(out_id.ctl.rs2), 64'(e.rs2));
			check_field("o_id.ctl.rd", 64'(out_id.ctl.rd), 64'(e.rd));
			check_field("o_id.ctl.imm", out_id.ctl.imm, e.imm);
			check_field("o_id.op_a", out_id.op_a, e.op_a);
			check_field("o_id.op_b", out_id.op_b, e.op_b);
			check_field("o_id.store_data", out_id.store_data, e.store_data);
		end
	endtask

	// nothing may come out once every instruction has emerged
	task automatic check_idle();
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			check_field("o_valid", 64'(out_valid), 64'(0));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		fetch_valid = 1'b0;
		fetch = '0;
		wb_en = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		n_inst = 0;
		read_trace();
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_field("o_valid", 64'(out_valid), 64'(0));
		end
		rst_n = 1'b1;
		fork
			drive_records();
			check_outputs();
		join
		check_idle();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/id_pkg.sv
rtl/stage_reg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/operand_sel.sv
rtl/id_stage.sv
tests/tb_clock.sv
tests/id_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the decode stage testbench with Verilator, run it, judge the log

set -u

cd "$(dirname "$0")" || exit 1

top=id_stage_tb
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module "$top" -o "$top" > "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat "$build_log"
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/"$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "TEST FAILED" "$sim_log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation finished cleanly"
exit 0

// ==== tests/id_trace.txt ====
# W rd data | I pc inst | E alu_op mem_op wb_sel flags rs1 rs2 rd imm op_a op_b store_data
# all hex; flags = {rs1_en rs2_en imm_en branch jump ebreak}; E records follow I order
W 01 1234
W 02 fffffffffffffff0
W 03 deadbeef
W 00 55
I 1000 002082b3
E 06 0 2 30 01 02 05 0 1234 fffffffffffffff0 0
I 1004 0230a333
E 0f 0 2 30 01 03 06 0 1234 deadbeef 0
I 1008 401103bb
E 11 0 2 30 02 01 07 0 fffffffffffffff0 1234 0
I 100c ffb08413
E 01 0 2 28 01 1b 08 fffffffffffffffb 1234 fffffffffffffffb 0
I 1010 40315493
E 03 0 2 28 02 03 09 403 fffffffffffffff0 403 0
I 1014 ff80b503
E d0 c 1 28 01 18 0a fffffffffffffff8 1234 fffffffffffffff8 0
I 1018 01014583
E 0b d 1 28 02 10 0b 10 fffffffffffffff0 10 0
I 101c 0041e603
E 2c f 1 28 03 04 0c 4 deadbeef 4 0
I 1020 00808683
E 1a 9 1 28 01 08 0d 8 1234 8 0
I 1024 00809683
E 34 a 1 28 01 08 0d 8 1234 8 0
I 1028 0080a683
E 68 b 1 28 01 08 0d 8 1234 8 0
I 102c 0080d683
E 16 e 1 28 01 08 0d 8 1234 8 0
I 1030 fe30b823
E 07 5 0 38 01 03 10 fffffffffffffff0 1234 fffffffffffffff0 deadbeef
I 1034 002081a3
E 41 1 0 38 01 02 03 3 1234 3 fffffffffffffff0
I 1038 00311123
E 82 2 0 38 02 03 02 2 fffffffffffffff0 2 deadbeef
I 103c 0011a623
E 81 4 0 38 03 01 0c c deadbeef c 1234
I 1040 fe209ce3
E 1c 0 0 3c 01 02 19 fffffffffffffff8 1234 fffffffffffffff8 0
I 1044 80000737
E 50 0 2 08 00 00 0e ffffffff80000000 0 ffffffff80000000 0
I 1048 12345797
E a0 0 2 08 08 03 0f 12345000 1048 12345000 0
I 104c ffdff86f
E 21 0 2 02 1f 1d 10 fffffffffffffffc 104c 0 0
I 1050 00c188e7
E 42 0 2 22 03 0c 11 c 1050 0 0
I 1054 00100073
E 84 0 2 09 00 01 00 1 0 1 0
I 1058 00100933
W 00 77
E 06 0 2 30 00 01 12 0 0 1234 0
I 105c 001249b3
W 04 abcdef
E c0 0 2 30 04 01 13 0 abcdef 1234 0
